/* hdl/l2_cfg.svh */
// Size parameters of the L2 local storage.
// Included by every RTL file and the testbench.
`ifndef L2_CFG_SVH
`define L2_CFG_SVH

// associativity
`define L2_WAYS       4
`define L2_WAY_BITS   2

// set index, the top bits pick the bank
`define L2_SET_BITS   6
`define L2_BANK_BITS  1
`define L2_BANKS      (1 << `L2_BANK_BITS)
`define L2_ROW_BITS   (`L2_SET_BITS - `L2_BANK_BITS)

// stored fields
`define L2_TAG_BITS   10
`define L2_LINE_BITS  64
`define L2_STATE_BITS 3

`endif

/* hdl/l2_pkg.sv */
// Types shared by the L2 local storage modules.
`include "l2_cfg.svh"

package l2_pkg;

    // one set index, seen whole or as bank and row
    typedef union packed {
        logic [`L2_SET_BITS-1:0] raw;
        struct packed {
            logic [`L2_BANK_BITS-1:0] bank;
            logic [`L2_ROW_BITS-1:0]  row;
        } split;
    } l2_set_u;

endpackage

/* hdl/l2_wr_if.sv */
// Decoded write port, driven by the write decoder and seen by every way.
`timescale 1ns/1ps
`include "l2_cfg.svh"

interface l2_wr_if ();

    logic [`L2_ROW_BITS-1:0]   row;
    logic [`L2_LINE_BITS-1:0]  line;
    logic [`L2_TAG_BITS-1:0]   tag;
    logic [`L2_STATE_BITS-1:0] state;

    // enables indexed [way][bank]
    logic [`L2_WAYS-1:0][`L2_BANKS-1:0] line_we;
    logic [`L2_WAYS-1:0][`L2_BANKS-1:0] tag_we;
    logic [`L2_WAYS-1:0][`L2_BANKS-1:0] state_we;

    modport decode (
        output row, line, tag, state,
        output line_we, tag_we, state_we
    );

    modport store (
        input row, line, tag, state,
        input line_we, tag_we, state_we
    );

endinterface

/* hdl/l2_bram.sv */
// Single-port synchronous RAM with a registered read-first output.
// The output only loads on rd_en and is cleared by reset.
`timescale 1ns/1ps

module l2_bram #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 32
) (
    input  logic                                       clk,
    input  logic                                       wr_rst,
    input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] addr,
    input  logic                                       we,
    input  logic                                       rd_en,
    input  logic [WIDTH-1:0]                           wdata,
    output logic [WIDTH-1:0]                           rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // nonblocking read sees the contents before this edge's write
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= mem[addr];
        end
    end

    addr_in_range: assert property (
        @(posedge clk) disable iff (wr_rst)
        (we || rd_en) |-> (int'(addr) < DEPTH)
    ) else $error("l2_bram address %0d out of range", addr);

endmodule

/* hdl/l2_wr_decode.sv */
// Turns the write strobes, way and set into per-way, per-bank enables.
// Purely combinational, so a write lands at the edge where its strobe is high.
`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_wr_decode import l2_pkg::*; (
    input  l2_set_u                   set_in,
    input  logic [`L2_WAY_BITS-1:0]   way,
    input  logic                      wr_en_line,
    input  logic                      wr_en_state,
    input  logic                      wr_en_fill,
    input  logic                      wr_en_all_ways,
    input  logic [`L2_LINE_BITS-1:0]  wr_data_line,
    input  logic [`L2_TAG_BITS-1:0]   wr_data_tag,
    input  logic [`L2_STATE_BITS-1:0] wr_data_state,
    l2_wr_if.decode                   wr
);

    logic [`L2_WAYS-1:0]  way_sel;
    logic [`L2_BANKS-1:0] bank_sel;
    logic                 line_req;
    logic                 tag_req;
    logic                 state_req;

    // a fill writes every field, broadcast forces the state write
    assign line_req  = wr_en_line | wr_en_fill;
    assign tag_req   = wr_en_fill;
    assign state_req = wr_en_state | wr_en_fill | wr_en_all_ways;

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            way_sel[w] = wr_en_all_ways || (int'(way) == w);
        end
        for (int b = 0; b < `L2_BANKS; b++) begin
            bank_sel[b] = (int'(set_in.split.bank) == b);
        end
    end

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            for (int b = 0; b < `L2_BANKS; b++) begin
                wr.line_we[w][b]  = line_req  & way_sel[w] & bank_sel[b];
                wr.tag_we[w][b]   = tag_req   & way_sel[w] & bank_sel[b];
                wr.state_we[w][b] = state_req & way_sel[w] & bank_sel[b];
            end
        end
    end

    assign wr.row   = set_in.split.row;
    assign wr.line  = wr_data_line;
    assign wr.tag   = wr_data_tag;
    assign wr.state = wr_data_state;

endmodule

/* hdl/l2_way_store.sv */
// Line, tag and state banks of one way.
// Every bank is read at once, the read select picks the right one.
`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_way_store #(
    parameter int WAY = 0
) (
    input  logic                      clk,
    input  logic                      wr_rst,
    input  logic                      rd_en,
    input  logic [`L2_ROW_BITS-1:0]   rd_row,
    l2_wr_if.store                    wr,
    output logic [`L2_LINE_BITS-1:0]  bank_line  [`L2_BANKS],
    output logic [`L2_TAG_BITS-1:0]   bank_tag   [`L2_BANKS],
    output logic [`L2_STATE_BITS-1:0] bank_state [`L2_BANKS]
);

    localparam int ROWS = 1 << `L2_ROW_BITS;

    logic [`L2_BANKS-1:0]   bank_we;
    logic [`L2_ROW_BITS-1:0] bank_addr [`L2_BANKS];

    genvar b;
    generate
        for (b = 0; b < `L2_BANKS; b++) begin : g_bank
            assign bank_we[b] = wr.line_we[WAY][b] | wr.tag_we[WAY][b]
                              | wr.state_we[WAY][b];

            // one port per RAM, a write owns the address
            assign bank_addr[b] = bank_we[b] ? wr.row : rd_row;

            l2_bram #(
                .WIDTH (`L2_LINE_BITS),
                .DEPTH (ROWS)
            ) line_ram (
                .clk    (clk),
                .wr_rst (wr_rst),
                .addr   (bank_addr[b]),
                .we     (wr.line_we[WAY][b]),
                .rd_en  (rd_en),
                .wdata  (wr.line),
                .rdata  (bank_line[b])
            );

            l2_bram #(
                .WIDTH (`L2_TAG_BITS),
                .DEPTH (ROWS)
            ) tag_ram (
                .clk    (clk),
                .wr_rst (wr_rst),
                .addr   (bank_addr[b]),
                .we     (wr.tag_we[WAY][b]),
                .rd_en  (rd_en),
                .wdata  (wr.tag),
                .rdata  (bank_tag[b])
            );

            l2_bram #(
                .WIDTH (`L2_STATE_BITS),
                .DEPTH (ROWS)
            ) state_ram (
                .clk    (clk),
                .wr_rst (wr_rst),
                .addr   (bank_addr[b]),
                .we     (wr.state_we[WAY][b]),
                .rd_en  (rd_en),
                .wdata  (wr.state),
                .rdata  (bank_state[b])
            );

            // read and write in one cycle must share the row, else the read misses
            same_row: assert property (
                @(posedge clk) disable iff (wr_rst)
                (bank_we[b] && rd_en) |-> (wr.row == rd_row)
            ) else $error("way %0d bank %0d read row differs from write row", WAY, b);
        end
    endgenerate

endmodule

/* hdl/l2_rd_select.sv */
// Registers the read bank and picks each way's bank output with it.
// The bank is held until the next read, so outputs stay stable meanwhile.
`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_rd_select import l2_pkg::*; (
    input  logic                      clk,
    input  logic                      wr_rst,
    input  logic                      rd_en,
    input  l2_set_u                   set_in,
    input  logic [`L2_LINE_BITS-1:0]  bank_line  [`L2_WAYS][`L2_BANKS],
    input  logic [`L2_TAG_BITS-1:0]   bank_tag   [`L2_WAYS][`L2_BANKS],
    input  logic [`L2_STATE_BITS-1:0] bank_state [`L2_WAYS][`L2_BANKS],
    output logic [`L2_LINE_BITS-1:0]  rd_line    [`L2_WAYS],
    output logic [`L2_TAG_BITS-1:0]   rd_tag     [`L2_WAYS],
    output logic [`L2_STATE_BITS-1:0] rd_state   [`L2_WAYS]
);

    logic [`L2_BANK_BITS-1:0] rd_bank;

    // the set may move on after the read, so keep the bank it asked for
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            rd_bank <= '0;
        end else if (rd_en) begin
            rd_bank <= set_in.split.bank;
        end
    end

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            rd_line[w]  = bank_line[w][rd_bank];
            rd_tag[w]   = bank_tag[w][rd_bank];
            rd_state[w] = bank_state[w][rd_bank];
        end
    end

endmodule

/* hdl/l2_localmem.sv */
// L2 cache slice local storage: line, tag and state per set and way, eviction way per set.
// Reads return all ways one cycle after rd_en; writes land at the strobe's edge.
`timescale 1ns/1ps
`include "l2_cfg.svh"

module l2_localmem import l2_pkg::*; (
    input  logic                      clk,
    input  logic                      wr_rst,
    input  logic                      rd_en,
    input  logic                      wr_en_line,
    input  logic                      wr_en_state,
    input  logic                      wr_en_fill,
    input  logic                      wr_en_all_ways,
    input  logic                      wr_en_evict_way,
    input  l2_set_u                   set_in,
    input  logic [`L2_WAY_BITS-1:0]   way,
    input  logic [`L2_LINE_BITS-1:0]  wr_data_line,
    input  logic [`L2_TAG_BITS-1:0]   wr_data_tag,
    input  logic [`L2_STATE_BITS-1:0] wr_data_state,
    input  logic [`L2_WAY_BITS-1:0]   wr_data_evict_way,
    output logic [`L2_LINE_BITS-1:0]  rd_line  [`L2_WAYS],
    output logic [`L2_TAG_BITS-1:0]   rd_tag   [`L2_WAYS],
    output logic [`L2_STATE_BITS-1:0] rd_state [`L2_WAYS],
    output logic [`L2_WAY_BITS-1:0]   rd_evict_way
);

    logic [`L2_LINE_BITS-1:0]  bank_line  [`L2_WAYS][`L2_BANKS];
    logic [`L2_TAG_BITS-1:0]   bank_tag   [`L2_WAYS][`L2_BANKS];
    logic [`L2_STATE_BITS-1:0] bank_state [`L2_WAYS][`L2_BANKS];

    l2_wr_if wr_bus ();

    l2_wr_decode wr_decode_i (
        .set_in         (set_in),
        .way            (way),
        .wr_en_line     (wr_en_line),
        .wr_en_state    (wr_en_state),
        .wr_en_fill     (wr_en_fill),
        .wr_en_all_ways (wr_en_all_ways),
        .wr_data_line   (wr_data_line),
        .wr_data_tag    (wr_data_tag),
        .wr_data_state  (wr_data_state),
        .wr             (wr_bus.decode)
    );

    genvar w;
    generate
        for (w = 0; w < `L2_WAYS; w++) begin : g_way
            l2_way_store #(
                .WAY (w)
            ) way_store_i (
                .clk        (clk),
                .wr_rst     (wr_rst),
                .rd_en      (rd_en),
                .rd_row     (set_in.split.row),
                .wr         (wr_bus.store),
                .bank_line  (bank_line[w]),
                .bank_tag   (bank_tag[w]),
                .bank_state (bank_state[w])
            );
        end
    endgenerate

    // eviction word is per set only, no banking needed
    l2_bram #(
        .WIDTH (`L2_WAY_BITS),
        .DEPTH (1 << `L2_SET_BITS)
    ) evict_ram_i (
        .clk    (clk),
        .wr_rst (wr_rst),
        .addr   (set_in.raw),
        .we     (wr_en_evict_way),
        .rd_en  (rd_en),
        .wdata  (wr_data_evict_way),
        .rdata  (rd_evict_way)
    );

    l2_rd_select rd_select_i (
        .clk        (clk),
        .wr_rst     (wr_rst),
        .rd_en      (rd_en),
        .set_in     (set_in),
        .bank_line  (bank_line),
        .bank_tag   (bank_tag),
        .bank_state (bank_state),
        .rd_line    (rd_line),
        .rd_tag     (rd_tag),
        .rd_state   (rd_state)
    );

endmodule

/* test/tb_l2_localmem.sv */
// Self-checking testbench for the L2 local storage.
// Drives fills, field writes and reads, and checks every read output against a reference model.
`timescale 1ns/1ps
`include "l2_cfg.svh"

module tb_l2_localmem import l2_pkg::*; ();

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 10;
    localparam int WAYS         = `L2_WAYS;
    localparam int SETS         = 1 << `L2_SET_BITS;
    localparam int ROWS         = 1 << `L2_ROW_BITS;
    localparam int SET_BITS     = `L2_SET_BITS;
    localparam int WAY_BITS     = `L2_WAY_BITS;
    localparam int LINE_BITS    = `L2_LINE_BITS;
    localparam int TAG_BITS     = `L2_TAG_BITS;
    localparam int STATE_BITS   = `L2_STATE_BITS;

    localparam int F_LINE  = 0;
    localparam int F_TAG   = 1;
    localparam int F_STATE = 2;
    localparam int F_EVICT = 3;

    localparam int N_FILL  = 48;
    localparam int N_MOD   = 8;
    localparam int N_BCAST = 8;
    localparam int N_PAIR  = 8;
    localparam int N_EVICT = 16;
    localparam int N_HOLD  = 4;

    // one clock cycle per operation
    localparam int OPS = 4 + SETS + N_FILL + SETS + 4 * N_MOD + 2 * N_BCAST + SETS
                       + 4 * N_PAIR + N_EVICT + SETS + 9 * N_HOLD + 2;

    logic                  clk;
    logic                  wr_rst;
    logic                  rd_en;
    logic                  wr_en_line;
    logic                  wr_en_state;
    logic                  wr_en_fill;
    logic                  wr_en_all_ways;
    logic                  wr_en_evict_way;
    l2_set_u               set_in;
    logic [WAY_BITS-1:0]   way;
    logic [LINE_BITS-1:0]  wr_data_line;
    logic [TAG_BITS-1:0]   wr_data_tag;
    logic [STATE_BITS-1:0] wr_data_state;
    logic [WAY_BITS-1:0]   wr_data_evict_way;
    logic [LINE_BITS-1:0]  rd_line  [WAYS];
    logic [TAG_BITS-1:0]   rd_tag   [WAYS];
    logic [STATE_BITS-1:0] rd_state [WAYS];
    logic [WAY_BITS-1:0]   rd_evict_way;

    // reference model of the stored contents
    logic [LINE_BITS-1:0]  m_line  [SETS][WAYS];
    logic [TAG_BITS-1:0]   m_tag   [SETS][WAYS];
    logic [STATE_BITS-1:0] m_state [SETS][WAYS];
    logic [WAY_BITS-1:0]   m_evict [SETS];

    // what the outputs must show since the last read
    logic [63:0] exp_val [WAYS][3];
    logic [63:0] exp_evict;

    int    seed;
    string test_name;

    l2_localmem l2_localmem_i (
        .clk               (clk),
        .wr_rst            (wr_rst),
        .rd_en             (rd_en),
        .wr_en_line        (wr_en_line),
        .wr_en_state       (wr_en_state),
        .wr_en_fill        (wr_en_fill),
        .wr_en_all_ways    (wr_en_all_ways),
        .wr_en_evict_way   (wr_en_evict_way),
        .set_in            (set_in),
        .way               (way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_state     (wr_data_state),
        .wr_data_evict_way (wr_data_evict_way),
        .rd_line           (rd_line),
        .rd_tag            (rd_tag),
        .rd_state          (rd_state),
        .rd_evict_way      (rd_evict_way)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [63:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] v;
        v = $random(seed);
        return int'(v[15:0]) % n;
    endfunction

    function automatic logic [63:0] ref_value(input int s, input int w, input int field);
        case (field)
            F_LINE:  return 64'(m_line[s][w]);
            F_TAG:   return 64'(m_tag[s][w]);
            F_STATE: return 64'(m_state[s][w]);
            default: return 64'(m_evict[s]);
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "read data mismatch");
        end
    endtask

    // the model takes a write at the edge where its strobe is high
    task automatic step();
        int s;
        @(posedge clk);
        s = int'(set_in.raw);
        for (int w = 0; w < WAYS; w++) begin
            if (wr_en_all_ways || w == int'(way)) begin
                if (wr_en_line || wr_en_fill) begin
                    m_line[s][w] = wr_data_line;
                end
                if (wr_en_fill) begin
                    m_tag[s][w] = wr_data_tag;
                end
                if (wr_en_state || wr_en_fill || wr_en_all_ways) begin
                    m_state[s][w] = wr_data_state;
                end
            end
        end
        if (wr_en_evict_way) begin
            m_evict[s] = wr_data_evict_way;
        end
        #2;
        rd_en           = 1'b0;
        wr_en_line      = 1'b0;
        wr_en_state     = 1'b0;
        wr_en_fill      = 1'b0;
        wr_en_all_ways  = 1'b0;
        wr_en_evict_way = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic drive_addr(input int s, input int w);
        set_in.raw = s[SET_BITS-1:0];
        way        = w[WAY_BITS-1:0];
    endtask

    task automatic fill(input int s, input int w);
        logic [63:0] r;
        r = rand_word();
        drive_addr(s, w);
        wr_data_line  = rand_word();
        wr_data_tag   = r[TAG_BITS-1:0];
        wr_data_state = r[TAG_BITS+STATE_BITS-1:TAG_BITS];
        wr_en_fill    = 1'b1;
        step();
    endtask

    task automatic write_line(input int s, input int w);
        drive_addr(s, w);
        wr_data_line = rand_word();
        wr_en_line   = 1'b1;
        step();
    endtask

    task automatic write_state(input int s, input int w);
        logic [63:0] r;
        r = rand_word();
        drive_addr(s, w);
        wr_data_state = r[STATE_BITS-1:0];
        wr_en_state   = 1'b1;
        step();
    endtask

    task automatic broadcast_state(input int s);
        logic [63:0] r;
        r = rand_word();
        drive_addr(s, rand_below(WAYS));
        wr_data_state  = r[STATE_BITS-1:0];
        wr_en_state    = 1'b1;
        wr_en_all_ways = 1'b1;
        step();
    endtask

    task automatic write_evict(input int s, input int w);
        logic [63:0] r;
        r = rand_word();
        drive_addr(s, w);
        wr_data_evict_way = r[WAY_BITS-1:0];
        wr_en_evict_way   = 1'b1;
        step();
    endtask

    task automatic read_set(input int s);
        drive_addr(s, 0);
        rd_en = 1'b1;
        step();
    endtask

    task automatic read_all_sets();
        for (int s = 0; s < SETS; s++) begin
            read_set(s);
        end
    endtask

    // every way and the eviction word get a known value, so no read returns X
    task automatic init_all_sets();
        logic [63:0] r;
        test_name = "init";
        for (int s = 0; s < SETS; s++) begin
            r = rand_word();
            drive_addr(s, 0);
            wr_data_line      = rand_word();
            wr_data_tag       = r[TAG_BITS-1:0];
            wr_data_state     = r[TAG_BITS+STATE_BITS-1:TAG_BITS];
            wr_data_evict_way = r[40+WAY_BITS-1:40];
            wr_en_fill        = 1'b1;
            wr_en_all_ways    = 1'b1;
            wr_en_evict_way   = 1'b1;
            step();
        end
    endtask

    task automatic random_fills();
        test_name = "random fill";
        for (int i = 0; i < N_FILL; i++) begin
            fill(rand_below(SETS), rand_below(WAYS));
        end
        read_all_sets();
    endtask

    task automatic field_writes();
        int s;
        int w;
        test_name = "line and state writes";
        for (int i = 0; i < N_MOD; i++) begin
            s = rand_below(SETS);
            w = rand_below(WAYS);
            write_line(s, w);
            read_set(s);
            write_state(s, w);
            read_set(s);
        end
    endtask

    task automatic broadcast_states();
        int s;
        test_name = "broadcast state";
        for (int i = 0; i < N_BCAST; i++) begin
            s = rand_below(SETS);
            broadcast_state(s);
            read_set(s);
        end
        read_all_sets();
    endtask

    // same row, other bank
    task automatic bank_pairs();
        int row;
        int w;
        test_name = "bank pairs";
        for (int i = 0; i < N_PAIR; i++) begin
            row = rand_below(ROWS);
            w   = rand_below(WAYS);
            fill(row, w);
            fill(row + ROWS, w);
            read_set(row);
            read_set(row + ROWS);
        end
    endtask

    task automatic evict_words();
        test_name = "eviction words";
        for (int i = 0; i < N_EVICT; i++) begin
            write_evict(rand_below(SETS), rand_below(WAYS));
        end
        read_all_sets();
    endtask

    // writes to the set just read must not move the outputs until the next read
    task automatic hold_outputs();
        int s;
        test_name = "hold";
        for (int i = 0; i < N_HOLD; i++) begin
            s = rand_below(SETS);
            read_set(s);
            fill(s, rand_below(WAYS));
            write_line(s, rand_below(WAYS));
            write_state(s, rand_below(WAYS));
            write_evict(s, rand_below(WAYS));
            idle(2);
            read_set(s);
            idle(1);
        end
    endtask

    // outputs are checked every cycle, then a read takes its snapshot (read-first)
    always @(negedge clk) begin
        if (!wr_rst) begin
            for (int w = 0; w < WAYS; w++) begin
                check($sformatf("%s way %0d line", test_name, w), exp_val[w][F_LINE],
                      64'(rd_line[w]));
                check($sformatf("%s way %0d tag", test_name, w), exp_val[w][F_TAG],
                      64'(rd_tag[w]));
                check($sformatf("%s way %0d state", test_name, w), exp_val[w][F_STATE],
                      64'(rd_state[w]));
            end
            check($sformatf("%s evict way", test_name), exp_evict, 64'(rd_evict_way));
            if (rd_en) begin
                for (int w = 0; w < WAYS; w++) begin
                    for (int f = F_LINE; f <= F_STATE; f++) begin
                        exp_val[w][f] = ref_value(int'(set_in.raw), w, f);
                    end
                end
                exp_evict = ref_value(int'(set_in.raw), 0, F_EVICT);
            end
        end
    end

    initial begin
        #(RESET_CYCLES * PERIOD + OPS * PERIOD * 4);
        $display("run timed out before all tests finished");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed              = 32'h92cc;
        clk               = 1'b0;
        wr_rst            = 1'b1;
        rd_en             = 1'b0;
        wr_en_line        = 1'b0;
        wr_en_state       = 1'b0;
        wr_en_fill        = 1'b0;
        wr_en_all_ways    = 1'b0;
        wr_en_evict_way   = 1'b0;
        set_in            = '0;
        way               = '0;
        wr_data_line      = '0;
        wr_data_tag       = '0;
        wr_data_state     = '0;
        wr_data_evict_way = '0;
        exp_evict         = '0;
        foreach (exp_val[w, f]) begin
            exp_val[w][f] = '0;
        end
        test_name = "after reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        wr_rst = 1'b0;
        idle(4);
        init_all_sets();
        random_fills();
        field_writes();
        broadcast_states();
        bank_pairs();
        evict_words();
        hold_outputs();
        idle(2);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* src.f */
+incdir+hdl
hdl/l2_pkg.sv
hdl/l2_wr_if.sv
hdl/l2_bram.sv
hdl/l2_wr_decode.sv
hdl/l2_way_store.sv
hdl/l2_rd_select.sv
hdl/l2_localmem.sv
test/tb_l2_localmem.sv

/* Makefile */
# Verilator simulation of the L2 local storage

TOP = tb_l2_localmem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check for a pass"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary -j 0 --timescale 1ns/1ps -f src.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
